//--- Makefile
SIM = obj_dir/Vtb_eeprom_ctrl

.PHONY: all lint clean

all: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx "No errors"

$(SIM): sources.f $(wildcard logic/*.sv testbench/*.sv)
	verilator --binary --timing --assert -f sources.f --top-module tb_eeprom_ctrl

lint:
	verilator --lint-only -Wall --top-module eeprom_ctrl \
		logic/eeprom_pkg.sv logic/i2c_pkg.sv logic/eeprom_request_sequencer.sv \
		logic/i2c_cmd_fifo.sv logic/i2c_bit_engine.sv logic/eeprom_ctrl.sv

clean:
	rm -rf obj_dir

//--- logic/eeprom_ctrl.sv
`timescale 1ns/1ps

module eeprom_ctrl #(
    parameter int SCL_HALF = 2,
    parameter int CMD_DEPTH = 4
) (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  eeprom_pkg::mem_addr_t addr,
    input  eeprom_pkg::mem_data_t wr_data,
    input  logic                  sda_in,
    output logic                  busy,
    output logic                  ack,
    output logic                  nack,
    output eeprom_pkg::mem_data_t rd_data,
    output logic                  scl,
    output logic                  sda_drive_low
);

    logic              push;
    logic              full;
    logic              pop;
    logic              not_empty;
    logic              done;
    i2c_pkg::bus_cmd_t cmd;
    i2c_pkg::bus_cmd_t head_cmd;

    assign ack = done;  // stop finished, transfer over

    eeprom_request_sequencer u_seq (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .full    (full),
        .done    (done),
        .busy    (busy),
        .push    (push),
        .cmd     (cmd)
    );

    i2c_cmd_fifo #(
        .CMD_DEPTH (CMD_DEPTH)
    ) u_fifo (
        .CLK       (CLK),
        .RESET     (RESET),
        .push      (push),
        .push_cmd  (cmd),
        .pop       (pop),
        .head_cmd  (head_cmd),
        .not_empty (not_empty),
        .full      (full)
    );

    i2c_bit_engine #(
        .SCL_HALF (SCL_HALF)
    ) u_engine (
        .CLK           (CLK),
        .RESET         (RESET),
        .not_empty     (not_empty),
        .head_cmd      (head_cmd),
        .sda_in        (sda_in),
        .pop           (pop),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .done          (done),
        .nack_seen     (nack),
        .read_byte     (rd_data)
    );

endmodule

//--- logic/eeprom_pkg.sv
package eeprom_pkg;

    // memory-level view of the 2 Kbyte two-wire EEPROM

    // byte address inside the device, bits 10..8 travel in the control byte
    typedef logic [10:0] mem_addr_t;

    typedef logic [7:0] mem_data_t;

    // upper nibble of every control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

endpackage

//--- logic/eeprom_request_sequencer.sv
`timescale 1ns/1ps

module eeprom_request_sequencer (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  eeprom_pkg::mem_addr_t addr,
    input  eeprom_pkg::mem_data_t wr_data,
    input  logic                  full,
    input  logic                  done,
    output logic                  busy,
    output logic                  push,
    output i2c_pkg::bus_cmd_t     cmd
);

    typedef enum logic [1:0] {
        IDLE,
        EMIT,
        WAIT_DONE
    } state_t;

    state_t                state;
    logic [2:0]            step;
    logic                  last_step;
    logic                  accept;
    logic                  is_read;
    eeprom_pkg::mem_addr_t req_addr;
    eeprom_pkg::mem_data_t req_data;

    assign accept = (state == IDLE) && (wr || rd);
    assign busy = (state != IDLE);
    assign push = (state == EMIT) && !full;  // hold the step while the FIFO is full
    assign last_step = is_read ? (step == 3'd6) : (step == 3'd4);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= IDLE;
            step <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    step <= '0;
                    if (accept)
                        state <= EMIT;
                end
                EMIT:
                begin
                    if (push)
                    begin
                        step <= step + 1'b1;
                        if (last_step)
                            state <= WAIT_DONE;
                    end
                end
                default:
                begin
                    if (done)  // stop has gone out on the bus
                        state <= IDLE;
                end
            endcase
        end
    end

    // request held for the whole transfer
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            is_read <= rd;
            req_addr <= addr;
            req_data <= wr_data;
        end
    end

    // step 1 and anything unlisted is the control byte with R/W low
    always_comb
    begin
        cmd.op = i2c_pkg::OP_WRITE;
        cmd.tx_byte = {eeprom_pkg::DEVICE_CODE, req_addr[10:8], 1'b0};
        cmd.last = 1'b0;
        case (step)
            3'd0: cmd.op = i2c_pkg::OP_START;
            3'd2: cmd.tx_byte = req_addr[7:0];
            3'd3:
            begin
                if (is_read)
                    cmd.op = i2c_pkg::OP_START;  // repeated start
                else
                    cmd.tx_byte = req_data;
            end
            3'd4:
            begin
                if (is_read)
                    cmd.tx_byte[0] = 1'b1;  // control byte, read direction
                else
                    cmd.op = i2c_pkg::OP_STOP;
            end
            3'd5:
            begin
                cmd.op = i2c_pkg::OP_READ;
                cmd.last = 1'b1;
            end
            3'd6: cmd.op = i2c_pkg::OP_STOP;
            default: ;
        endcase
    end

    done_while_waiting: assert property (@(posedge CLK) disable iff (RESET)
        done |-> (state == WAIT_DONE))
        else $error("bit engine finished a stop outside a queued transfer");

    single_strobe: assert property (@(posedge CLK) disable iff (RESET)
        (state == IDLE) |-> !(wr && rd))
        else $error("wr and rd together");

endmodule

//--- logic/i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine #(
    parameter int SCL_HALF = 2  // CLK cycles per SCL half period, at least 2
) (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  not_empty,
    input  i2c_pkg::bus_cmd_t     head_cmd,
    input  logic                  sda_in,
    output logic                  pop,
    output logic                  scl,
    output logic                  sda_drive_low,
    output logic                  done,
    output logic                  nack_seen,
    output eeprom_pkg::mem_data_t read_byte
);

    localparam int CNT_W = (SCL_HALF > 1) ? $clog2(SCL_HALF) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SCL_HALF - 1);
    localparam logic [CNT_W-1:0] CNT_MID = CNT_W'(SCL_HALF / 2 - 1);

    typedef enum logic [2:0] {
        IDLE,
        START,
        BITS,
        ACK,
        STOP
    } state_t;

    state_t                state;
    logic                  half;     // 0 while scl low, 1 while high
    logic [CNT_W-1:0]      cnt;
    logic [2:0]            bit_cnt;
    logic                  tick;
    logic                  mid;
    logic                  sda_next;
    logic                  bus_free; // last thing on the bus was a stop
    eeprom_pkg::mem_data_t shreg;
    logic                  op_read;
    logic                  op_last;

    assign tick = (cnt == CNT_LAST);
    assign mid = (cnt == CNT_MID);
    assign pop = (state == IDLE) && not_empty;

    // level put on SDA in the middle of the low half
    always_comb
    begin
        case (state)
            STOP: sda_next = 1'b1;
            BITS: sda_next = !op_read && !shreg[7];
            ACK: sda_next = op_read && !op_last;  // master ack unless last
            default: sda_next = 1'b0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= IDLE;
            half <= 1'b0;
            cnt <= '0;
            bit_cnt <= '0;
            scl <= 1'b1;
            sda_drive_low <= 1'b0;
            done <= 1'b0;
            nack_seen <= 1'b0;
            bus_free <= 1'b1;
        end
        else
        begin
            done <= 1'b0;
            if (state == IDLE)
            begin
                cnt <= '0;
                half <= 1'b0;
                bit_cnt <= '0;
                if (not_empty)
                begin
                    scl <= 1'b0;
                    case (head_cmd.op)
                        i2c_pkg::OP_START:
                        begin
                            state <= START;
                            bus_free <= 1'b0;
                            if (bus_free)
                                nack_seen <= 1'b0;  // new transfer
                        end
                        i2c_pkg::OP_STOP: state <= STOP;
                        default: state <= BITS;
                    endcase
                end
            end
            else
            begin
                cnt <= tick ? '0 : cnt + 1'b1;
                if (tick)
                    half <= ~half;

                if (!half && mid)
                    sda_drive_low <= sda_next;
                if (half && mid && state == START)
                    sda_drive_low <= 1'b1;  // SDA falls, SCL high
                if (half && mid && state == STOP)
                    sda_drive_low <= 1'b0;  // SDA rises, SCL high

                if (!half && tick)
                begin
                    scl <= 1'b1;
                    if (state == ACK && !op_read && sda_in)
                        nack_seen <= 1'b1;
                end

                if (half && tick)
                begin
                    case (state)
                        BITS:
                        begin
                            scl <= 1'b0;
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7)
                                state <= ACK;
                        end
                        STOP:
                        begin
                            state <= IDLE;
                            done <= 1'b1;
                            bus_free <= 1'b1;
                        end
                        default: state <= IDLE;  // scl stays high between ops
                    endcase
                end
            end
        end
    end

    // byte shifting, msb first in both directions
    always_ff @(posedge CLK)
    begin
        if (pop)
        begin
            shreg <= head_cmd.tx_byte;
            op_read <= (head_cmd.op == i2c_pkg::OP_READ);
            op_last <= head_cmd.last;
        end
        else if (state == BITS && tick)
        begin
            if (!half && op_read)
                read_byte <= {read_byte[6:0], sda_in};
            if (half)
                shreg <= {shreg[6:0], 1'b0};
        end
    end

    sda_stable_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        $changed(sda_drive_low) && !(state inside {START, STOP}) |-> !scl)
        else $error("sda changed while scl high outside start/stop");

endmodule

//--- logic/i2c_cmd_fifo.sv
`timescale 1ns/1ps

module i2c_cmd_fifo #(
    parameter int CMD_DEPTH = 4  // power of two
) (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              push,
    input  i2c_pkg::bus_cmd_t push_cmd,
    input  logic              pop,
    output i2c_pkg::bus_cmd_t head_cmd,
    output logic              not_empty,
    output logic              full
);

    localparam int PTR_W = $clog2(CMD_DEPTH);

    i2c_pkg::bus_cmd_t mem [CMD_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;
    logic              do_push;
    logic              do_pop;

    assign do_push = push && !full;
    assign do_pop = pop && not_empty;

    assign head_cmd = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign full = (count == (PTR_W+1)'(CMD_DEPTH));

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (do_push)
            mem[wr_ptr] <= push_cmd;
    end

    no_pop_when_empty: assert property (@(posedge CLK) disable iff (RESET)
        pop |-> not_empty)
        else $error("engine popped an empty command FIFO");

endmodule

//--- logic/i2c_pkg.sv
package i2c_pkg;

    // one bus operation per FIFO entry
    typedef enum logic [1:0] {
        OP_START,   // also used as repeated start
        OP_WRITE,
        OP_READ,
        OP_STOP
    } bus_op_t;

    typedef struct packed {
        bus_op_t               op;
        eeprom_pkg::mem_data_t tx_byte;  // byte sent by OP_WRITE
        logic                  last;     // OP_READ answers with nack
    } bus_cmd_t;

endpackage

//--- sources.f
logic/eeprom_pkg.sv
logic/i2c_pkg.sv
logic/eeprom_request_sequencer.sv
logic/i2c_cmd_fifo.sv
logic/i2c_bit_engine.sv
logic/eeprom_ctrl.sv
testbench/eeprom_model.sv
testbench/tb_eeprom_ctrl.sv

//--- testbench/eeprom_model.sv
`timescale 1ns/1ps

module eeprom_model (
    input  logic scl,
    input  logic sda,
    output logic sda_low
);

    eeprom_pkg::mem_data_t mem [2048];
    eeprom_pkg::mem_addr_t ptr;
    eeprom_pkg::mem_data_t shreg;
    eeprom_pkg::mem_data_t tx_byte;
    eeprom_pkg::mem_data_t wdata;
    logic scl_q;
    logic sda_q;
    logic active;   // addressed and still taking part
    logic rx;       // 1 while receiving from the master
    logic refuse;
    logic read_dir;
    logic wrote;
    int   bit_cnt;  // 8 is the acknowledge slot
    int   phase;    // 0 control, 1 address, 2 data
    int   busy_left;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hff;
        sda_low = 1'b0;
        scl_q = 1'b1;
        sda_q = 1'b1;
        active = 1'b0;
        rx = 1'b1;
        refuse = 1'b0;
        read_dir = 1'b0;
        wrote = 1'b0;
        bit_cnt = 0;
        phase = 0;
        busy_left = 0;
        ptr = '0;
    end

    always @(posedge scl or negedge scl or posedge sda or negedge sda)
    begin
        if (scl && scl_q && sda_q && !sda)
        begin
            // start or repeated start
            active = 1'b1;
            rx = 1'b1;
            bit_cnt = 0;
            phase = 0;
            wrote = 1'b0;
            refuse = 1'b0;
        end
        else if (scl && scl_q && !sda_q && sda)
        begin
            if (wrote)
            begin
                mem[ptr] = wdata;
                busy_left = 2;  // internal write cycle
            end
            else if (busy_left > 0)
                busy_left--;
            active = 1'b0;
            wrote = 1'b0;
            sda_low = 1'b0;
        end
        else if (!scl_q && scl && active)
        begin
            if (bit_cnt < 8)
            begin
                if (rx)
                    shreg = {shreg[6:0], sda};
                else
                    tx_byte = tx_byte << 1;
                bit_cnt++;
                if (bit_cnt == 8 && rx)
                begin
                    case (phase)
                        0:
                        begin
                            refuse = (shreg[7:4] != eeprom_pkg::DEVICE_CODE) || (busy_left > 0);
                            read_dir = shreg[0];
                            ptr[10:8] = shreg[3:1];
                            phase = 1;
                        end
                        1:
                        begin
                            ptr[7:0] = shreg;
                            phase = 2;
                        end
                        default:
                        begin
                            wdata = shreg;
                            wrote = 1'b1;
                        end
                    endcase
                end
            end
            else
            begin
                bit_cnt = 0;
                if (!rx || refuse)
                    active = 1'b0;  // read done, or busy
                else if (read_dir)
                begin
                    rx = 1'b0;
                    tx_byte = mem[ptr];
                end
            end
        end
        else if (scl_q && !scl)
        begin
            if (!active)
                sda_low = 1'b0;
            else if (bit_cnt == 8)
                sda_low = rx && !refuse;
            else
                sda_low = !rx && !tx_byte[7];
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

//--- testbench/tb_eeprom_ctrl.sv
`timescale 1ns/1ps

module tb_eeprom_ctrl;

    localparam int TIMEOUT = 2000;
    localparam int MAX_TRIES = 5;

    logic                  CLK = 1'b0;
    logic                  RESET;
    logic                  wr;
    logic                  rd;
    eeprom_pkg::mem_addr_t addr;
    eeprom_pkg::mem_data_t wr_data;
    logic                  busy;
    logic                  ack;
    logic                  nack;
    eeprom_pkg::mem_data_t rd_data;
    logic                  scl;
    logic                  dut_sda_low;
    logic                  mem_sda_low;
    logic                  sda;

    eeprom_pkg::mem_data_t shadow [2048];
    int                    errors;
    int                    ack_count;
    logic                  aborted;
    logic                  exp_is_read;
    eeprom_pkg::mem_data_t exp_data;
    logic [31:0]           rng;

    assign sda = !(dut_sda_low || mem_sda_low);  // pull-up, either side pulls low

    always #2 CLK = ~CLK;

    eeprom_ctrl #(
        .SCL_HALF  (2),
        .CMD_DEPTH (4)
    ) u_dut (
        .CLK           (CLK),
        .RESET         (RESET),
        .wr            (wr),
        .rd            (rd),
        .addr          (addr),
        .wr_data       (wr_data),
        .sda_in        (sda),
        .busy          (busy),
        .ack           (ack),
        .nack          (nack),
        .rd_data       (rd_data),
        .scl           (scl),
        .sda_drive_low (dut_sda_low)
    );

    eeprom_model u_mem (
        .scl     (scl),
        .sda     (sda),
        .sda_low (mem_sda_low)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // last byte written there, else the erased value
    function automatic eeprom_pkg::mem_data_t expected_read(input eeprom_pkg::mem_addr_t a);
        return shadow[a];
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    always @(negedge CLK)
    begin
        if (!RESET && ack)
        begin
            ack_count++;
            if (exp_is_read && !nack)
                check("rd_data", rd_data, exp_data);
        end
    end

    task automatic wait_ack(output logic got_nack);
        int n;
        n = 0;
        got_nack = 1'b1;
        while (!ack && n < TIMEOUT)
        begin
            @(negedge CLK);
            n++;
        end
        if (!ack)
        begin
            errors++;
            $display("no ack from controller at %0t", $time);
            aborted = 1'b1;
        end
        else
        begin
            got_nack = nack;
            @(negedge CLK);
            check("busy", busy, 1'b0);
        end
    endtask

    task automatic transfer(input logic is_read, input eeprom_pkg::mem_addr_t a,
                            input eeprom_pkg::mem_data_t d, output logic got_nack);
        got_nack = 1'b1;
        if (aborted)
            return;
        exp_is_read = is_read;
        exp_data = expected_read(a);
        wr = !is_read;
        rd = is_read;
        addr = a;
        wr_data = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        check("busy", busy, 1'b1);
        wait_ack(got_nack);
    endtask

    task automatic write_retry(input eeprom_pkg::mem_addr_t a, input eeprom_pkg::mem_data_t d);
        logic nk;
        nk = 1'b1;
        for (int t = 0; t < MAX_TRIES && nk && !aborted; t++)
            transfer(1'b0, a, d, nk);
        if (!nk)
            shadow[a] = d;
        else if (!aborted)
        begin
            errors++;
            $display("write to %h never acknowledged", a);
        end
    endtask

    task automatic read_retry(input eeprom_pkg::mem_addr_t a);
        logic nk;
        nk = 1'b1;
        for (int t = 0; t < MAX_TRIES && nk && !aborted; t++)
            transfer(1'b1, a, 8'h00, nk);
        if (nk && !aborted)
        begin
            errors++;
            $display("read of %h never acknowledged", a);
        end
    endtask

    // request right after a write lands in the write cycle
    task automatic busy_window_check(input eeprom_pkg::mem_addr_t a,
                                     input eeprom_pkg::mem_data_t d);
        logic nk;
        write_retry(a, d);
        transfer(1'b0, a, ~d, nk);
        if (!aborted)
            check("nack", nk, 1'b1);
        read_retry(a);
    endtask

    task automatic ignored_strobe_check(input eeprom_pkg::mem_addr_t a,
                                        input eeprom_pkg::mem_data_t d);
        int   acks_before;
        logic nk;
        if (aborted)
            return;
        acks_before = ack_count;
        exp_is_read = 1'b0;
        wr = 1'b1;
        addr = a;
        wr_data = d;
        @(negedge CLK);
        wr = 1'b0;
        repeat (3) @(negedge CLK);
        check("busy", busy, 1'b1);
        rd = 1'b1;
        addr = a ^ 11'h100;
        @(negedge CLK);
        rd = 1'b0;
        repeat (3) @(negedge CLK);
        check("busy", busy, 1'b1);
        wr = 1'b1;
        addr = a ^ 11'h200;
        wr_data = ~d;
        @(negedge CLK);
        wr = 1'b0;
        wait_ack(nk);
        if (aborted)
            return;
        repeat (400) @(negedge CLK);  // no second transfer may follow
        check("ack_count", ack_count - acks_before, 1);
        if (!nk)
            shadow[a] = d;
        read_retry(a);
        read_retry(a ^ 11'h200);
    endtask

    task automatic finish_run;
        $display("run complete, %0d errors", errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    endtask

    initial
    begin
        eeprom_pkg::mem_addr_t a;
        eeprom_pkg::mem_addr_t b;
        eeprom_pkg::mem_data_t d;
        wr = 1'b0;
        rd = 1'b0;
        addr = '0;
        wr_data = '0;
        RESET = 1'b1;
        errors = 0;
        ack_count = 0;
        aborted = 1'b0;
        exp_is_read = 1'b0;
        exp_data = '0;
        rng = 32'hf2ee97f6;
        for (int i = 0; i < 2048; i++)
            shadow[i] = 8'hff;
        repeat (10) @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);

        check("busy", busy, 1'b0);
        check("ack", ack, 1'b0);
        check("nack", nack, 1'b0);
        check("scl", scl, 1'b1);
        check("sda_drive_low", dut_sda_low, 1'b0);

        write_retry(11'h123, 8'h5a);
        write_retry(11'h045, 8'h11);
        read_retry(11'h045);
        read_retry(11'h123);

        // pairs that differ only in the block bits
        for (int i = 0; i < 12; i++)
        begin
            rng = xorshift(rng);
            a = rng[10:0];
            d = rng[18:11];
            b = a ^ {rng[21:19] | 3'b001, 8'h00};
            write_retry(a, d);
            write_retry(b, ~d);
            read_retry(a);
            read_retry(b);
        end

        for (int i = 0; i < 30; i++)
        begin
            rng = xorshift(rng);
            if (rng[31])
                write_retry(rng[10:0], rng[18:11]);
            else
                read_retry(rng[10:0]);
        end

        rng = xorshift(rng);
        busy_window_check(rng[10:0], rng[18:11]);
        rng = xorshift(rng);
        ignored_strobe_check(rng[10:0], rng[18:11]);

        finish_run;
    end

endmodule
